// File: Bender.yml
package:
  name: mouse_if

sources:
  - src/mouse_pkg.sv
  - src/uart_pkg.sv
  - src/uart_rx.sv
  - src/packet_parser.sv
  - src/mouse_regs.sv
  - src/mouse_if_top.sv
  - target: simulation
    files:
      - bench/mouse_if_sva.sv
      - bench/tb_mouse_if.sv

// File: bench/mouse_if_sva.sv
// strobe and x checks on the top level; all properties are off while rst is high
`timescale 1ns/10ps

module mouse_if_sva (
	input logic        clk,
	input logic        rst,
	input logic        rda,
	input logic        frame_done,
	input logic        enable,
	input logic [15:0] rdata
);

	// receive strobe is one cycle wide
	a_rda_pulse: assert property (@(posedge clk) disable iff (rst) rda |=> !rda)
		else $error("rda high for two cycles in a row");

	a_done_pulse: assert property (@(posedge clk) disable iff (rst) frame_done |=> !frame_done)
		else $error("frame_done high for two cycles in a row");

	// a frame completes only with enable high now and in its last read cycle
	a_done_enable: assert property (@(posedge clk) disable iff (rst)
		frame_done |-> enable && $past(enable))
		else $error("frame_done high while enable is low");

	a_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({rdata, rda, frame_done, enable}))
		else $error("unknown value on a top level signal after reset");

endmodule

bind mouse_if_top mouse_if_sva u_mouse_if_sva (
	.clk        (clk),
	.rst        (rst),
	.rda        (rda),
	.frame_done (frame_done),
	.enable     (enable),
	.rdata      (rdata)
);

// File: bench/tb_mouse_if.sv
// drives 8N1 serial reports from a fixed seed and checks host reads against a byte-level model
`timescale 1ns/10ps

module tb_mouse_if;

	localparam int num_frames = 450;

	logic        clk;
	logic        rst;
	logic        rx;
	logic [1:0]  addr;
	logic        wr;
	logic [15:0] wdata;
	logic [15:0] rdata;

	logic [31:0] rng;
	// byte-level parser model and expected register contents
	int          m_state;
	int          m_idx;
	logic [7:0]  m_bytes [6];
	logic [15:0] exp_status;
	logic [15:0] exp_x;
	logic [15:0] exp_y;
	logic [7:0]  exp_count;
	logic        exp_enable;
	int          accepted;
	int          checks;
	int          errors;
	int          timeouts;

	mouse_if_top DUT (
		.clk   (clk),
		.rst   (rst),
		.rx    (rx),
		.addr  (addr),
		.wr    (wr),
		.wdata (wdata),
		.rdata (rdata)
	);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// xorshift32, state in rng
	function automatic logic [31:0] next_random();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	// hunt 0, second start byte 1, data 2
	task automatic model_byte(input logic [7:0] b);
		if (!exp_enable) begin
			m_state = 0;
		end else if (m_state == 0) begin
			if (b == mouse_pkg::start_byte_1) begin
				m_state = 1;
			end
		end else if (m_state == 1) begin
			// mismatch is dropped, never taken as a new first byte
			m_idx   = 0;
			m_state = (b == mouse_pkg::start_byte_2) ? 2 : 0;
		end else begin
			m_bytes[m_idx] = b;
			m_idx          = m_idx + 1;
			if (m_idx == 6) begin
				// high byte arrives first
				exp_status = {m_bytes[0], m_bytes[1]};
				exp_x      = {m_bytes[2], m_bytes[3]};
				exp_y      = {m_bytes[4], m_bytes[5]};
				exp_count  = exp_count + 8'd1;
				accepted++;
				m_state = 0;
			end
		end
	endtask

	// start bit, lsb first data, stop bit, then a random idle gap
	task automatic send_byte(input logic [7:0] b);
		logic [31:0] gap;
		model_byte(b);
		rx <= 1'b0;
		repeat (uart_pkg::clks_per_bit) @(posedge clk);
		for (int i = 0; i < uart_pkg::data_bits; i++) begin
			rx <= b[i];
			repeat (uart_pkg::clks_per_bit) @(posedge clk);
		end
		rx <= 1'b1;
		repeat (uart_pkg::clks_per_bit) @(posedge clk);
		gap = next_random() % 8;
		repeat (gap) @(posedge clk);
	endtask

	// kind 0 clean, 1 bad first byte, 2 bad second then fresh pattern, 3 bad second only
	task automatic send_frame(input int kind);
		logic [7:0] bad;
		bad = 8'(next_random());
		if (kind == 1) begin
			if (bad == mouse_pkg::start_byte_1) begin
				bad = ~bad;
			end
			send_byte(bad);
			send_byte(mouse_pkg::start_byte_2);
		end else if (kind >= 2) begin
			// sometimes a repeated 0xBA as the bad byte
			if (bad[7]) begin
				bad = mouse_pkg::start_byte_1;
			end else if (bad == mouse_pkg::start_byte_2) begin
				bad = ~bad;
			end
			send_byte(mouse_pkg::start_byte_1);
			send_byte(bad);
		end
		if (kind == 0 || kind == 2) begin
			send_byte(mouse_pkg::start_byte_1);
			send_byte(mouse_pkg::start_byte_2);
		end
		for (int i = 0; i < 6; i++) begin
			// 0xBA 0xBA 0x11 must not open a frame
			if (i == 0 && kind == 3 && bad == mouse_pkg::start_byte_1) begin
				send_byte(mouse_pkg::start_byte_2);
			end else begin
				send_byte(8'(next_random()));
			end
		end
	endtask

	task automatic host_write(input logic [1:0] a, input logic [15:0] d);
		wr    <= 1'b1;
		addr  <= a;
		wdata <= d;
		@(posedge clk);
		wr <= 1'b0;
		@(posedge clk);
		if (a == mouse_pkg::addr_ctrl) begin
			exp_enable = d[mouse_pkg::ctrl_enable_bit];
			// disabled parser parks in the hunt
			if (!exp_enable) begin
				m_state = 0;
			end
		end
	endtask

	// read port is combinational, sample mid-cycle
	task automatic check_reg(input logic [1:0] a, input logic [15:0] expected, input string name);
		addr <= a;
		@(negedge clk);
		checks++;
		assert (rdata === expected) else begin
			errors++;
			$display("Fail at time %0t: rdata (%s) expected %h, actual %h",
				$time, name, expected, rdata);
		end
		@(posedge clk);
	endtask

	task automatic check_all();
		logic [15:0] exp_ctrl;
		// count in bits 15 to 8, enable in bit 0
		exp_ctrl = {exp_count, 7'd0, exp_enable};
		check_reg(mouse_pkg::addr_status, exp_status, "status");
		check_reg(mouse_pkg::addr_x, exp_x, "x");
		check_reg(mouse_pkg::addr_y, exp_y, "y");
		check_reg(mouse_pkg::addr_ctrl, exp_ctrl, "ctrl");
	endtask

	// poll the count field until the model's count shows up
	task automatic wait_frame();
		logic reached;
		reached = 1'b0;
		addr <= mouse_pkg::addr_ctrl;
		for (int k = 0; k < 40 && !reached; k++) begin
			@(negedge clk);
			reached = (rdata[15 -: mouse_pkg::count_width] == exp_count);
		end
		if (!reached) begin
			timeouts++;
			$display("Timeout: frame count still not %0d 40 cycles after the stop bit", exp_count);
		end
		@(posedge clk);
	endtask

	initial begin
		int r;
		rng        = 32'hf841;
		m_state    = 0;
		m_idx      = 0;
		exp_status = 16'd0;
		exp_x      = 16'd0;
		exp_y      = 16'd0;
		exp_count  = 8'd0;
		exp_enable = 1'b1;
		accepted   = 0;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		rst   <= 1'b1;
		rx    <= 1'b1;
		addr  <= 2'd0;
		wr    <= 1'b0;
		wdata <= 16'd0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		// reset state, only enable set
		check_all();
		for (int f = 0; f < num_frames; f++) begin
			// disabled window, upper ctrl bits random
			if (f == 100) begin
				host_write(mouse_pkg::addr_ctrl, 16'(next_random()) & 16'hfffe);
				check_all();
			end
			if (f == 130) begin
				host_write(mouse_pkg::addr_ctrl, 16'(next_random()) | 16'h0001);
				check_all();
			end
			// data registers are read only
			if (next_random() % 4 == 0) begin
				host_write(2'(next_random() % 3), 16'(next_random()));
				check_all();
			end
			r = int'(next_random() % 8);
			send_frame(r < 5 ? 0 : r - 4);
			wait_frame();
			check_all();
		end
		// counter has to have wrapped
		checks++;
		assert (accepted > 256) else begin
			errors++;
			$display("Only %0d frames accepted, frame counter never wrapped", accepted);
		end
		$display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: src/mouse_if_top.sv
// mouse report receiver top; serial in, 2-bit host register port, no interrupt output
`timescale 1ns/10ps

module mouse_if_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        rx,
	input  logic [1:0]  addr,
	input  logic        wr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata
);

	logic [7:0]  rx_byte;
	logic        rda;
	logic [15:0] status_word;
	logic [15:0] x_word;
	logic [15:0] y_word;
	logic        frame_done;
	logic        enable;

	// serial line to bytes
	uart_rx u_uart_rx (
		.clk     (clk),
		.rst     (rst),
		.rx      (rx),
		.rx_byte (rx_byte),
		.rda     (rda)
	);

	// bytes to frames, steered by enable
	packet_parser u_packet_parser (
		.clk         (clk),
		.rst         (rst),
		.rda         (rda),
		.rx_byte     (rx_byte),
		.enable      (enable),
		.status_word (status_word),
		.x_word      (x_word),
		.y_word      (y_word),
		.frame_done  (frame_done)
	);

	// host side
	mouse_regs u_mouse_regs (
		.clk         (clk),
		.rst         (rst),
		.frame_done  (frame_done),
		.status_word (status_word),
		.x_word      (x_word),
		.y_word      (y_word),
		.wr          (wr),
		.addr        (addr),
		.wdata       (wdata),
		.rdata       (rdata),
		.enable      (enable)
	);

endmodule

// File: src/mouse_pkg.sv
// report protocol constants and host register map; frame layout is fixed at 0xBA 0x11 plus six bytes
package mouse_pkg;

	// start pattern, first byte then second
	localparam logic [7:0] start_byte_1 = 8'hBA;
	localparam logic [7:0] start_byte_2 = 8'h11;

	// host register map
	localparam logic [1:0] addr_status = 2'd0;
	localparam logic [1:0] addr_x      = 2'd1;
	localparam logic [1:0] addr_y      = 2'd2;
	localparam logic [1:0] addr_ctrl   = 2'd3;

	// control word layout
	// enable in the low bit
	localparam int ctrl_enable_bit = 0;

	// frame counter sits in the top byte of the control word
	localparam int count_width = 8;

endpackage

// File: src/mouse_regs.sv
// frame latch and host registers; only the ctrl address is writable, and only its enable bit
`timescale 1ns/10ps

module mouse_regs (
	input  logic        clk,
	input  logic        rst,
	input  logic        frame_done,
	input  logic [15:0] status_word,
	input  logic [15:0] x_word,
	input  logic [15:0] y_word,
	input  logic        wr,
	input  logic [1:0]  addr,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        enable
);

	logic [15:0]                     status_q;
	logic [15:0]                     x_q;
	logic [15:0]                     y_q;
	logic [mouse_pkg::count_width-1:0] frame_cnt;

	// snapshot of the last complete frame
	// counter wraps naturally at its width
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			status_q  <= 16'd0;
			x_q       <= 16'd0;
			y_q       <= 16'd0;
			frame_cnt <= '0;
		end else if (frame_done) begin
			status_q  <= status_word;
			x_q       <= x_word;
			y_q       <= y_word;
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	// enable comes out of reset set
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			enable <= 1'b1;
		end else if (wr && addr == mouse_pkg::addr_ctrl) begin
			enable <= wdata[mouse_pkg::ctrl_enable_bit];
		end
	end

	// combinational read port
	always_comb begin
		rdata = 16'd0;
		case (addr)
			mouse_pkg::addr_status: rdata = status_q;
			mouse_pkg::addr_x:      rdata = x_q;
			mouse_pkg::addr_y:      rdata = y_q;
			default: begin
				// count in the top byte, enable in bit 0
				rdata[15 -: mouse_pkg::count_width]  = frame_cnt;
				rdata[mouse_pkg::ctrl_enable_bit]    = enable;
			end
		endcase
	end

endmodule

// File: src/packet_parser.sv
// fixed six-byte frame after 0xBA 0x11; a mismatching start byte is discarded, never rechecked
`timescale 1ns/10ps

module packet_parser (
	input  logic        clk,
	input  logic        rst,
	input  logic        rda,
	input  logic [7:0]  rx_byte,
	input  logic        enable,
	output logic [15:0] status_word,
	output logic [15:0] x_word,
	output logic [15:0] y_word,
	output logic        frame_done
);

	// wait states idle on rda, read states look at rx_byte one cycle later
	localparam logic [2:0] ST_WAIT_S1 = 3'd0;
	localparam logic [2:0] ST_READ_S1 = 3'd1;
	localparam logic [2:0] ST_WAIT_S2 = 3'd2;
	localparam logic [2:0] ST_READ_S2 = 3'd3;
	localparam logic [2:0] ST_WAIT_D  = 3'd4;
	localparam logic [2:0] ST_READ_D  = 3'd5;

	logic [2:0]  state;
	logic [2:0]  next_state;
	logic [2:0]  byte_idx;
	logic [2:0]  next_byte_idx;
	logic [15:0] next_status_word;
	logic [15:0] next_x_word;
	logic [15:0] next_y_word;
	logic        done_q;
	logic        next_done;

	// a pending strobe dies with enable
	assign frame_done = done_q & enable;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= ST_WAIT_S1;
			byte_idx    <= 3'd0;
			status_word <= 16'd0;
			x_word      <= 16'd0;
			y_word      <= 16'd0;
			done_q      <= 1'b0;
		end else begin
			state       <= next_state;
			byte_idx    <= next_byte_idx;
			status_word <= next_status_word;
			x_word      <= next_x_word;
			y_word      <= next_y_word;
			done_q      <= next_done;
		end
	end

	always_comb begin
		next_state       = state;
		next_byte_idx    = byte_idx;
		next_status_word = status_word;
		next_x_word      = x_word;
		next_y_word      = y_word;
		next_done        = 1'b0;
		case (state)
			ST_WAIT_S1: begin
				if (rda) begin
					next_state = ST_READ_S1;
				end
			end
			ST_READ_S1: begin
				// anything but the first start byte keeps hunting
				if (rx_byte == mouse_pkg::start_byte_1) begin
					next_state = ST_WAIT_S2;
				end else begin
					next_state = ST_WAIT_S1;
				end
			end
			ST_WAIT_S2: begin
				if (rda) begin
					next_state = ST_READ_S2;
				end
			end
			ST_READ_S2: begin
				// bad second byte goes back to the hunt
				if (rx_byte == mouse_pkg::start_byte_2) begin
					next_byte_idx = 3'd0;
					next_state    = ST_WAIT_D;
				end else begin
					next_state = ST_WAIT_S1;
				end
			end
			ST_WAIT_D: begin
				if (rda) begin
					next_state = ST_READ_D;
				end
			end
			ST_READ_D: begin
				// high byte of each word comes first
				case (byte_idx)
					3'd0:    next_status_word[15:8] = rx_byte;
					3'd1:    next_status_word[7:0]  = rx_byte;
					3'd2:    next_x_word[15:8]      = rx_byte;
					3'd3:    next_x_word[7:0]       = rx_byte;
					3'd4:    next_y_word[15:8]      = rx_byte;
					default: next_y_word[7:0]       = rx_byte;
				endcase
				if (byte_idx == 3'd5) begin
					next_done  = 1'b1;
					next_state = ST_WAIT_S1;
				end else begin
					next_byte_idx = byte_idx + 3'd1;
					next_state    = ST_WAIT_D;
				end
			end
			default: begin
				next_state = ST_WAIT_S1;
			end
		endcase
		// disabled means parked in the hunt, partial frame abandoned
		if (!enable) begin
			next_state = ST_WAIT_S1;
			next_done  = 1'b0;
		end
	end

endmodule

// File: src/uart_pkg.sv
// serial link constants for 8N1 only; clks_per_bit must stay even and at least 8
package uart_pkg;

	// oversampling ratio, clock cycles per serial bit
	localparam logic [15:0] clks_per_bit = 16'd16;

	// payload bits per character
	localparam int data_bits = 8;

endpackage

// File: src/uart_rx.sv
// 8N1 receiver with no parity; a byte with a low stop bit is dropped without a strobe
`timescale 1ns/10ps

module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx,
	output logic [7:0] rx_byte,
	output logic       rda
);

	// receiver states
	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA  = 2'd2;
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic                           rx_meta;
	logic                           rx_sync;
	logic                           rx_prev;
	logic [1:0]                     state;
	logic [15:0]                    tick_cnt;
	logic [3:0]                     bit_cnt;
	logic [uart_pkg::data_bits-1:0] shift_reg;
	logic                           start_fall;
	logic                           start_mid;
	logic                           bit_end;

	// high to low on the synchronised line
	assign start_fall = rx_prev & ~rx_sync;

	// half a bit into the start bit, pulled in by the two sync stages
	assign start_mid = (tick_cnt == (uart_pkg::clks_per_bit >> 1) - 16'd3);

	// one full bit after the previous sample point
	assign bit_end = (tick_cnt == uart_pkg::clks_per_bit - 16'd1);

	// two-flop synchroniser plus one stage for edge detect
	// idle line is high
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= RX_IDLE;
			tick_cnt <= 16'd0;
			bit_cnt  <= 4'd0;
			rx_byte  <= 8'd0;
			rda      <= 1'b0;
		end else begin
			// strobe lasts one cycle
			rda <= 1'b0;
			case (state)
				RX_IDLE: begin
					tick_cnt <= 16'd0;
					if (start_fall) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (start_mid) begin
						tick_cnt <= 16'd0;
						bit_cnt  <= 4'd0;
						// line back high means a glitch, not a start bit
						state    <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						tick_cnt <= tick_cnt + 16'd1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						tick_cnt <= 16'd0;
						if (bit_cnt == 4'(uart_pkg::data_bits - 1)) begin
							state <= RX_STOP;
						end else begin
							bit_cnt <= bit_cnt + 4'd1;
						end
					end else begin
						tick_cnt <= tick_cnt + 16'd1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						tick_cnt <= 16'd0;
						state    <= RX_IDLE;
						// present only with a good stop bit
						if (rx_sync) begin
							rx_byte <= shift_reg;
							rda     <= 1'b1;
						end
					end else begin
						tick_cnt <= tick_cnt + 16'd1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_end) begin
			shift_reg <= {rx_sync, shift_reg[uart_pkg::data_bits-1:1]};
		end
	end

endmodule

// File: vlog.f
src/mouse_pkg.sv
src/uart_pkg.sv
src/uart_rx.sv
src/packet_parser.sv
src/mouse_regs.sv
src/mouse_if_top.sv
bench/mouse_if_sva.sv
bench/tb_mouse_if.sv
